// ==== filelist.f ====
hw/fpu_ic_pkg.sv
hw/fp_noncomp_unit.sv
hw/fpu_wrapper.sv
hw/fpu_interconnect.sv
hw/shared_fpu_top.sv
sim/shared_fpu_assert.sv
sim/tb_shared_fpu.sv

// ==== Bender.yml ====
package:
  name: shared_fpu

sources:
  # RTL in compile order
  - files:
      - hw/fpu_ic_pkg.sv
      - hw/fp_noncomp_unit.sv
      - hw/fpu_wrapper.sv
      - hw/fpu_interconnect.sv
      - hw/shared_fpu_top.sv
  # Simulation only
  - target: simulation
    files:
      - sim/shared_fpu_assert.sv
      - sim/tb_shared_fpu.sv

// ==== sim/tb_shared_fpu.sv ====
`timescale 1ns/100ps
// --------------------------------------------------
// Shared FPU subsystem testbench
// --------------------------------------------------
module tb_shared_fpu;

  // One stimulus row with its expected response
  typedef struct {
    string                             name;
    int unsigned                       core;
    fpu_ic_pkg::fpu_op_e               op;
    fpu_ic_pkg::fp_rnd_t               sub;
    logic [fpu_ic_pkg::DATA_WIDTH-1:0] a;
    logic [fpu_ic_pkg::DATA_WIDTH-1:0] b;
    logic [fpu_ic_pkg::DATA_WIDTH-1:0] res;
    fpu_ic_pkg::fp_status_t            flags;
  } vec_t;

  logic                            clk = 1'b0;
  logic                            rst_n;
  logic [fpu_ic_pkg::NB_CORES-1:0] apu_req;
  logic [fpu_ic_pkg::NB_CORES-1:0] apu_gnt;
  fpu_ic_pkg::apu_req_t            apu_req_data [fpu_ic_pkg::NB_CORES];
  logic [fpu_ic_pkg::NB_CORES-1:0] apu_rvalid;
  logic [fpu_ic_pkg::NB_CORES-1:0] apu_rready;
  fpu_ic_pkg::apu_rsp_t            apu_rsp;

  // Directed table with per-core request and scoreboard queues
  vec_t        table_q [$];
  vec_t        pend_q [fpu_ic_pkg::NB_CORES][$];
  vec_t        sb_q [fpu_ic_pkg::NB_CORES][$];
  int unsigned n_random = 200;
  logic [31:0] lcg_state = 32'd6699;
  // Last granted core for the alternation check
  bit          have_last = 1'b0;
  int unsigned last_gnt = 0;
  int unsigned err_result = 0;
  int unsigned err_flags = 0;
  int unsigned err_id = 0;
  int unsigned err_other = 0;

  shared_fpu_top dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .apu_req_i      (apu_req),
    .apu_gnt_o      (apu_gnt),
    .apu_req_data_i (apu_req_data),
    .apu_rvalid_o   (apu_rvalid),
    .apu_rready_i   (apu_rready),
    .apu_rsp_o      (apu_rsp)
  );

  bind shared_fpu_top shared_fpu_assert assert_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (apu_req_i),
    .gnt_i    (apu_gnt_o),
    .rvalid_i (apu_rvalid_o),
    .rready_i (apu_rready_i),
    .rsp_i    (apu_rsp_o)
  );

  always begin
    #5 clk = ~clk;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Sign injection rule with unknown sub-ops acting as J
  function automatic logic [31:0] sgnj_expect(input logic [31:0] a, input logic [31:0] b,
                                              input fpu_ic_pkg::fp_rnd_t sub);
    logic sign;
    case (sub)
      3'd1:    sign = !b[31];
      3'd2:    sign = a[31] ^ b[31];
      default: sign = b[31];
    endcase
    return {sign, a[30:0]};
  endfunction

  // Core sends the other core's ID so the interconnect must overwrite it
  function automatic fpu_ic_pkg::apu_req_t build_req(input vec_t v, input int unsigned core);
    fpu_ic_pkg::apu_req_t r;
    r.op_a  = v.a;
    r.op_b  = v.b;
    r.op    = v.op;
    r.flags = v.sub;
    r.id    = fpu_ic_pkg::ID_WIDTH'(fpu_ic_pkg::NB_CORES - 1 - core);
    return r;
  endfunction

  function automatic int unsigned outstanding();
    int unsigned n;
    n = 0;
    for (int unsigned c = 0; c < fpu_ic_pkg::NB_CORES; c++) begin
      n += pend_q[c].size() + sb_q[c].size();
    end
    return n;
  endfunction

  function automatic int unsigned total_errors();
    return err_result + err_flags + err_id + err_other + dut_i.assert_i.fail_count;
  endfunction

  task automatic add_row(input string name, input int unsigned core,
                         input fpu_ic_pkg::fpu_op_e op, input int unsigned sub,
                         input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] res, input bit nv);
    vec_t v;
    v.name     = name;
    v.core     = core;
    v.op       = op;
    v.sub      = fpu_ic_pkg::fp_rnd_t'(sub);
    v.a        = a;
    v.b        = b;
    v.res      = res;
    v.flags    = '0;
    v.flags.nv = nv;
    table_q.push_back(v);
  endtask

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_result(input string name,
                              input logic [fpu_ic_pkg::DATA_WIDTH-1:0] exp_v,
                              input logic [fpu_ic_pkg::DATA_WIDTH-1:0] act_v);
    if (act_v !== exp_v) begin
      err_result++;
      $display("Fail %s: result expected %h, actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic check_flags(input string name, input fpu_ic_pkg::fp_status_t exp_v,
                             input fpu_ic_pkg::fp_status_t act_v);
    if (act_v !== exp_v) begin
      err_flags++;
      $display("Fail %s: flags expected %b, actual %b", name, exp_v, act_v);
    end
  endtask

  task automatic check_id(input string name, input logic [fpu_ic_pkg::ID_WIDTH-1:0] exp_v,
                          input logic [fpu_ic_pkg::ID_WIDTH-1:0] act_v);
    if (act_v !== exp_v) begin
      err_id++;
      $display("Fail %s: id expected %h, actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic print_summary();
    $display("Error counts: result %0d, flags %0d, id %0d, other %0d, assertion %0d",
             err_result, err_flags, err_id, err_other, dut_i.assert_i.fail_count);
  endtask

  // --------------------------------------------------
  // Port driving and monitoring
  // --------------------------------------------------
  // Present queue heads and pick rready on the rising edge
  task automatic drive_ports(input bit stall);
    logic [31:0] rnd;
    for (int unsigned c = 0; c < fpu_ic_pkg::NB_CORES; c++) begin
      rnd = lcg_next();
      if (pend_q[c].size() != 0) begin
        apu_req[c]      <= 1'b1;
        apu_req_data[c] <= build_req(pend_q[c][0], c);
      end else begin
        apu_req[c] <= 1'b0;
      end
      // About one stall cycle in four
      apu_rready[c] <= stall ? (rnd[31:30] != 2'b00) : 1'b1;
    end
  endtask

  // Sample stable ports on the falling edge before the next transfer edge
  task automatic observe_ports();
    vec_t item;
    for (int unsigned c = 0; c < fpu_ic_pkg::NB_CORES; c++) begin
      if (apu_gnt[c] && !apu_req[c]) begin
        err_other++;
        $display("Grant given to core %0d which is not requesting", c);
      end else if (apu_gnt[c]) begin
        if ((&apu_req) && have_last && (c == last_gnt)) begin
          err_other++;
          $display("Core %0d granted twice in a row while both cores requested", c);
        end
        have_last = 1'b1;
        last_gnt  = c;
        item = pend_q[c].pop_front();
        sb_q[c].push_back(item);
      end
      if (apu_rvalid[c] && apu_rready[c]) begin
        if (sb_q[c].size() == 0) begin
          err_other++;
          $display("Response to core %0d with no request outstanding", c);
        end else begin
          item = sb_q[c].pop_front();
          check_result(item.name, item.res, apu_rsp.result);
          check_flags(item.name, item.flags, apu_rsp.flags);
          check_id(item.name, fpu_ic_pkg::ID_WIDTH'(c), apu_rsp.id);
        end
      end
    end
  endtask

  task automatic run_traffic(input bit stall);
    while (outstanding() != 0) begin
      @(posedge clk);
      drive_ports(stall);
      @(negedge clk);
      observe_ports();
    end
    @(posedge clk);
    apu_req    <= '0;
    apu_rready <= '1;
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic build_table();
    // Sign injection including a folded sub-op
    add_row("sgnj_j", 0, fpu_ic_pkg::OP_SGNJ, 0, 'h3F800000, 'hC0000000, 'hBF800000, 0);
    add_row("sgnj_jn", 1, fpu_ic_pkg::OP_SGNJ, 1, 'hBF800000, 'hC0000000, 'h3F800000, 0);
    add_row("sgnj_jx", 0, fpu_ic_pkg::OP_SGNJ, 2, 'hBF800000, 'hC0000000, 'h3F800000, 0);
    add_row("sgnj_j_qnan", 1, fpu_ic_pkg::OP_SGNJ, 0, 'h7FC00000, 'h80000000, 'hFFC00000, 0);
    add_row("sgnj_jx_snan", 0, fpu_ic_pkg::OP_SGNJ, 2, 'hFF800001, 'h3F800000, 'hFF800001, 0);
    add_row("sgnj_fold", 1, fpu_ic_pkg::OP_SGNJ, 7, 'h40000000, 'hBF800000, 'hC0000000, 0);
    // Min / max
    add_row("min_ord", 0, fpu_ic_pkg::OP_MINMAX, 0, 'h3F800000, 'h40000000, 'h3F800000, 0);
    add_row("max_neg", 1, fpu_ic_pkg::OP_MINMAX, 1, 'hBF800000, 'hC0000000, 'hBF800000, 0);
    add_row("min_zeros", 0, fpu_ic_pkg::OP_MINMAX, 0, 'h00000000, 'h80000000, 'h80000000, 0);
    add_row("max_zeros", 1, fpu_ic_pkg::OP_MINMAX, 1, 'h80000000, 'h00000000, 'h00000000, 0);
    add_row("min_qnan", 0, fpu_ic_pkg::OP_MINMAX, 0, 'h7FC00000, 'h40000000, 'h40000000, 0);
    add_row("max_two_nan", 1, fpu_ic_pkg::OP_MINMAX, 1, 'h7FC00001, 'hFFC00000, 'h7FC00000, 0);
    add_row("min_snan", 0, fpu_ic_pkg::OP_MINMAX, 0, 'h7F800001, 'h3F800000, 'h3F800000, 1);
    add_row("mm_fold", 1, fpu_ic_pkg::OP_MINMAX, 5, 'h3F800000, 'h40000000, 'h3F800000, 0);
    // Compare
    add_row("le_equal", 0, fpu_ic_pkg::OP_CMP, 0, 'h3F800000, 'h3F800000, 'h00000001, 0);
    add_row("lt_equal", 1, fpu_ic_pkg::OP_CMP, 1, 'h3F800000, 'h3F800000, 'h00000000, 0);
    add_row("lt_neg", 0, fpu_ic_pkg::OP_CMP, 1, 'hC0000000, 'hBF800000, 'h00000001, 0);
    add_row("le_greater", 1, fpu_ic_pkg::OP_CMP, 0, 'h40000000, 'h3F800000, 'h00000000, 0);
    add_row("eq_zeros", 0, fpu_ic_pkg::OP_CMP, 2, 'h80000000, 'h00000000, 'h00000001, 0);
    add_row("lt_zeros", 1, fpu_ic_pkg::OP_CMP, 1, 'h80000000, 'h00000000, 'h00000000, 0);
    add_row("le_qnan", 0, fpu_ic_pkg::OP_CMP, 0, 'h7FC00000, 'h3F800000, 'h00000000, 1);
    add_row("eq_qnan", 1, fpu_ic_pkg::OP_CMP, 2, 'h7FC00000, 'h7FC00000, 'h00000000, 0);
    add_row("eq_snan", 0, fpu_ic_pkg::OP_CMP, 2, 'h3F800000, 'h7F800001, 'h00000000, 1);
    // Classify with one row per class
    add_row("cls_ninf", 1, fpu_ic_pkg::OP_CLASS, 0, 'hFF800000, 'h0, 'h001, 0);
    add_row("cls_nnorm", 0, fpu_ic_pkg::OP_CLASS, 0, 'hBF800000, 'h0, 'h002, 0);
    add_row("cls_nsub", 1, fpu_ic_pkg::OP_CLASS, 0, 'h80000001, 'h0, 'h004, 0);
    add_row("cls_nzero", 0, fpu_ic_pkg::OP_CLASS, 0, 'h80000000, 'h0, 'h008, 0);
    add_row("cls_pzero", 1, fpu_ic_pkg::OP_CLASS, 0, 'h00000000, 'h0, 'h010, 0);
    add_row("cls_psub", 0, fpu_ic_pkg::OP_CLASS, 0, 'h00000001, 'h0, 'h020, 0);
    add_row("cls_pnorm", 1, fpu_ic_pkg::OP_CLASS, 0, 'h3F800000, 'h0, 'h040, 0);
    add_row("cls_pinf", 0, fpu_ic_pkg::OP_CLASS, 0, 'h7F800000, 'h0, 'h080, 0);
    add_row("cls_snan", 1, fpu_ic_pkg::OP_CLASS, 0, 'h7F800001, 'h0, 'h100, 0);
    add_row("cls_qnan", 0, fpu_ic_pkg::OP_CLASS, 0, 'h7FC00000, 'h0, 'h200, 0);
  endtask

  // Random sign injection over any operands and sub-op codes
  task automatic load_random();
    vec_t        v;
    logic [31:0] rnd;
    for (int unsigned n = 0; n < n_random; n++) begin
      rnd     = lcg_next();
      v.name  = $sformatf("rand_%0d", n);
      v.core  = rnd[31:16] % fpu_ic_pkg::NB_CORES;
      v.op    = fpu_ic_pkg::OP_SGNJ;
      v.sub   = fpu_ic_pkg::fp_rnd_t'(rnd[15:13]);
      v.a     = lcg_next();
      v.b     = lcg_next();
      v.res   = sgnj_expect(v.a, v.b, v.sub);
      v.flags = '0;
      pend_q[v.core].push_back(v);
    end
  endtask

  initial begin : main
    rst_n      = 1'b0;
    apu_req    = '0;
    apu_rready = '1;
    for (int unsigned c = 0; c < fpu_ic_pkg::NB_CORES; c++) begin
      apu_req_data[c] = '0;
    end
    build_table();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    // Directed phase with rready held high
    foreach (table_q[i]) begin
      pend_q[table_q[i].core].push_back(table_q[i]);
    end
    run_traffic(1'b0);
    // Random phase under rready stalls
    load_random();
    run_traffic(1'b1);
    repeat (2) @(posedge clk);
    print_summary();
    if (total_errors() == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Twenty cycles per request is far above the worst stalled rate
  initial begin : watchdog
    int unsigned limit;
    @(posedge rst_n);
    limit = (table_q.size() + n_random) * 20 + 100;
    repeat (limit) @(posedge clk);
    $display("Timeout: requests still outstanding after %0d cycles", limit);
    print_summary();
    $display("Regression failed");
    $finish;
  end

endmodule

// ==== sim/shared_fpu_assert.sv ====
`timescale 1ns/100ps
// --------------------------------------------------
// Shared FPU protocol assertions
// --------------------------------------------------
module shared_fpu_assert (
  input logic                            clk,
  input logic                            rst_n,
  input logic [fpu_ic_pkg::NB_CORES-1:0] req_i,
  input logic [fpu_ic_pkg::NB_CORES-1:0] gnt_i,
  input logic [fpu_ic_pkg::NB_CORES-1:0] rvalid_i,
  input logic [fpu_ic_pkg::NB_CORES-1:0] rready_i,
  input fpu_ic_pkg::apu_rsp_t            rsp_i
);

  // Number of assertion failures so far
  int unsigned fail_count = 0;

  // --------------------------------------------------
  // Arbitration
  // --------------------------------------------------
  // At most one core granted per cycle
  gnt_onehot_a : assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt_i))
    else begin
      fail_count++;
      $error("grant raised for more than one core: %b", gnt_i);
    end

  // Grant only toward a requesting core
  gnt_req_a : assert property (@(posedge clk) disable iff (!rst_n) (gnt_i & ~req_i) == '0)
    else begin
      fail_count++;
      $error("grant raised for an idle core: gnt %b req %b", gnt_i, req_i);
    end

  // --------------------------------------------------
  // Response side
  // --------------------------------------------------
  rvalid_onehot_a : assert property (@(posedge clk) disable iff (!rst_n) $onehot0(rvalid_i))
    else begin
      fail_count++;
      $error("response valid raised for more than one core: %b", rvalid_i);
    end

  // Stalled response keeps valid and data
  stall_hold_a : assert property (@(posedge clk) disable iff (!rst_n)
    (|(rvalid_i & ~rready_i)) |=> (rvalid_i == $past(rvalid_i)) && $stable(rsp_i))
    else begin
      fail_count++;
      $error("response changed while stalled");
    end

  // Quiet outputs while in reset
  reset_quiet_a : assert property (@(posedge clk)
    !rst_n |-> (gnt_i == '0) && (rvalid_i == '0))
    else begin
      fail_count++;
      $error("grant or response valid during reset");
    end

endmodule

// ==== hw/shared_fpu_top.sv ====
`timescale 1ns/100ps
// -----------------------------------------------
// Shared FPU subsystem top
// -----------------------------------------------
module shared_fpu_top (
  input  logic                            clk,
  input  logic                            rst_n,
  // Per-core request ports
  input  logic [fpu_ic_pkg::NB_CORES-1:0] apu_req_i,
  output logic [fpu_ic_pkg::NB_CORES-1:0] apu_gnt_o,
  input  fpu_ic_pkg::apu_req_t            apu_req_data_i [fpu_ic_pkg::NB_CORES],
  // Per-core response ports
  output logic [fpu_ic_pkg::NB_CORES-1:0] apu_rvalid_o,
  input  logic [fpu_ic_pkg::NB_CORES-1:0] apu_rready_i,
  output fpu_ic_pkg::apu_rsp_t            apu_rsp_o
);

  // Interconnect to wrapper
  logic                 ic_req;
  logic                 ic_gnt;
  fpu_ic_pkg::apu_req_t ic_req_data;
  // Wrapper to interconnect
  logic                 ic_rvalid;
  logic                 ic_rready;
  fpu_ic_pkg::apu_rsp_t ic_rsp;

  fpu_interconnect interconnect_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .core_req_i      (apu_req_i),
    .core_gnt_o      (apu_gnt_o),
    .core_req_data_i (apu_req_data_i),
    .core_rvalid_o   (apu_rvalid_o),
    .core_rready_i   (apu_rready_i),
    .core_rsp_o      (apu_rsp_o),
    .fpu_req_o       (ic_req),
    .fpu_gnt_i       (ic_gnt),
    .fpu_req_data_o  (ic_req_data),
    .fpu_rvalid_i    (ic_rvalid),
    .fpu_rready_o    (ic_rready),
    .fpu_rsp_i       (ic_rsp)
  );

  fpu_wrapper wrapper_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .apu_req_i      (ic_req),
    .apu_gnt_o      (ic_gnt),
    .apu_req_data_i (ic_req_data),
    .apu_rvalid_o   (ic_rvalid),
    .apu_rready_i   (ic_rready),
    .apu_rsp_o      (ic_rsp)
  );

endmodule

// ==== hw/fpu_interconnect.sv ====
`timescale 1ns/100ps
// -----------------------------------------------
// Round-robin APU interconnect
// -----------------------------------------------
module fpu_interconnect (
  input  logic                                clk,
  input  logic                                rst_n,
  // Core request ports
  input  logic [fpu_ic_pkg::NB_CORES-1:0]     core_req_i,
  output logic [fpu_ic_pkg::NB_CORES-1:0]     core_gnt_o,
  input  fpu_ic_pkg::apu_req_t                core_req_data_i [fpu_ic_pkg::NB_CORES],
  // Core response ports, data shared
  output logic [fpu_ic_pkg::NB_CORES-1:0]     core_rvalid_o,
  input  logic [fpu_ic_pkg::NB_CORES-1:0]     core_rready_i,
  output fpu_ic_pkg::apu_rsp_t                core_rsp_o,
  // Toward the wrapper
  output logic                                fpu_req_o,
  input  logic                                fpu_gnt_i,
  output fpu_ic_pkg::apu_req_t                fpu_req_data_o,
  // From the wrapper
  input  logic                                fpu_rvalid_i,
  output logic                                fpu_rready_o,
  input  fpu_ic_pkg::apu_rsp_t                fpu_rsp_i
);

  // Core with top priority this cycle
  logic [fpu_ic_pkg::ID_WIDTH-1:0] rr_ptr;
  // Winning core
  logic [fpu_ic_pkg::ID_WIDTH-1:0] sel_idx;
  logic                            any_req;
  logic                            req_fire;

  // -----------------------------------------------
  // Arbitration
  // -----------------------------------------------
  assign any_req  = |core_req_i;
  assign req_fire = fpu_req_o && fpu_gnt_i;

  // First requester at or after the pointer
  always_comb begin : pick_comb
    int unsigned cand;
    logic        found;
    found   = 1'b0;
    sel_idx = '0;
    for (int unsigned i = 0; i < fpu_ic_pkg::NB_CORES; i++) begin
      cand = (32'(rr_ptr) + i) % fpu_ic_pkg::NB_CORES;
      if (!found && core_req_i[cand]) begin
        found   = 1'b1;
        sel_idx = fpu_ic_pkg::ID_WIDTH'(cand);
      end
    end
  end

  // Forward the winner, ID replaced by its index
  always_comb begin : fwd_comb
    fpu_req_data_o    = core_req_data_i[sel_idx];
    fpu_req_data_o.id = sel_idx;
  end

  assign fpu_req_o = any_req;

  // Grant only the winner, only while the wrapper is ready
  always_comb begin : gnt_comb
    core_gnt_o = '0;
    if (any_req && fpu_gnt_i) begin
      core_gnt_o[sel_idx] = 1'b1;
    end
  end

  // Pointer moves past the granted core
  always_ff @(posedge clk or negedge rst_n) begin : ptr_ff
    if (!rst_n) begin
      rr_ptr <= '0;
    end else if (req_fire) begin
      rr_ptr <= fpu_ic_pkg::ID_WIDTH'((32'(sel_idx) + 1) % fpu_ic_pkg::NB_CORES);
    end
  end

  // -----------------------------------------------
  // Response routing
  // -----------------------------------------------
  // Valid only toward the core named by the ID
  always_comb begin : rvalid_comb
    core_rvalid_o = '0;
    if (fpu_rvalid_i) begin
      core_rvalid_o[fpu_rsp_i.id] = 1'b1;
    end
  end

  // Back-pressure from the addressed core
  assign fpu_rready_o = core_rready_i[fpu_rsp_i.id];
  assign core_rsp_o   = fpu_rsp_i;

endmodule

// ==== hw/fpu_wrapper.sv ====
`timescale 1ns/100ps
// -----------------------------------------------
// APU wrapper for the FP32 unit
// -----------------------------------------------
module fpu_wrapper (
  input  logic                 clk,
  input  logic                 rst_n,
  // APU request side
  input  logic                 apu_req_i,
  output logic                 apu_gnt_o,
  input  fpu_ic_pkg::apu_req_t apu_req_data_i,
  // APU response side
  output logic                 apu_rvalid_o,
  input  logic                 apu_rready_i,
  output fpu_ic_pkg::apu_rsp_t apu_rsp_o
);

  fpu_ic_pkg::fpu_op_e  dec_op;
  fpu_ic_pkg::fp_rnd_t  raw_rnd;
  fpu_ic_pkg::fp_rnd_t  dec_rnd;
  fpu_ic_pkg::fpu_req_t unit_req;

  // -----------------------------------------------
  // Opcode and flag unpacking
  // -----------------------------------------------
  assign dec_op  = fpu_ic_pkg::fpu_op_e'(apu_req_data_i.op);
  assign raw_rnd = fpu_ic_pkg::fp_rnd_t'(apu_req_data_i.flags);

  // Unknown sub-op codes fold to the group's first entry
  always_comb begin : rnd_fold_comb
    dec_rnd = raw_rnd;
    case (dec_op)
      fpu_ic_pkg::OP_SGNJ: begin
        if (!(raw_rnd inside {fpu_ic_pkg::SGNJ_J, fpu_ic_pkg::SGNJ_JN, fpu_ic_pkg::SGNJ_JX})) begin
          dec_rnd = fpu_ic_pkg::SGNJ_J;
        end
      end
      fpu_ic_pkg::OP_MINMAX: begin
        if (!(raw_rnd inside {fpu_ic_pkg::MM_MIN, fpu_ic_pkg::MM_MAX})) begin
          dec_rnd = fpu_ic_pkg::MM_MIN;
        end
      end
      fpu_ic_pkg::OP_CMP: begin
        if (!(raw_rnd inside {fpu_ic_pkg::CMP_LE, fpu_ic_pkg::CMP_LT, fpu_ic_pkg::CMP_EQ})) begin
          dec_rnd = fpu_ic_pkg::CMP_LE;
        end
      end
      // Classify has no sub-op
      default: begin
        dec_rnd = '0;
      end
    endcase
  end

  assign unit_req.op_a = apu_req_data_i.op_a;
  assign unit_req.op_b = apu_req_data_i.op_b;
  assign unit_req.op   = dec_op;
  assign unit_req.rnd  = dec_rnd;
  // ID rides along as the unit tag
  assign unit_req.tag  = apu_req_data_i.id;

  // -----------------------------------------------
  // Execution unit
  // -----------------------------------------------
  // Grant is the unit's input ready
  fp_noncomp_unit noncomp_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (apu_req_i),
    .in_ready_o  (apu_gnt_o),
    .in_req_i    (unit_req),
    .out_valid_o (apu_rvalid_o),
    .out_ready_i (apu_rready_i),
    .out_rsp_o   (apu_rsp_o)
  );

endmodule

// ==== hw/fp_noncomp_unit.sv ====
`timescale 1ns/100ps
// -----------------------------------------------
// FP32 non-computational pipeline
// -----------------------------------------------
module fp_noncomp_unit (
  input  logic                 clk,
  input  logic                 rst_n,
  // Request channel
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  fpu_ic_pkg::fpu_req_t in_req_i,
  // Response channel
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output fpu_ic_pkg::apu_rsp_t out_rsp_o
);

  // Operand class, computed in stage 1
  typedef struct packed {
    logic sign;
    logic zero;
    logic subnormal;
    logic normal;
    logic inf;
    logic qnan;
    logic snan;
  } fp_class_t;

  function automatic fp_class_t classify(input logic [fpu_ic_pkg::DATA_WIDTH-1:0] val);
    fp_class_t                       c;
    logic [fpu_ic_pkg::EXP_BITS-1:0] expo;
    logic [fpu_ic_pkg::MAN_BITS-1:0] mant;
    expo   = val[fpu_ic_pkg::DATA_WIDTH-2 -: fpu_ic_pkg::EXP_BITS];
    mant   = val[fpu_ic_pkg::MAN_BITS-1:0];
    c      = '0;
    c.sign = val[fpu_ic_pkg::DATA_WIDTH-1];
    if (expo == '0) begin
      c.zero      = (mant == '0);
      c.subnormal = (mant != '0);
    end else if (expo == '1) begin
      c.inf  = (mant == '0);
      // Quiet bit is the mantissa MSB
      c.qnan = mant[fpu_ic_pkg::MAN_BITS-1];
      c.snan = !mant[fpu_ic_pkg::MAN_BITS-1] && (mant != '0);
    end else begin
      c.normal = 1'b1;
    end
    return c;
  endfunction

  // Stage 1 state
  logic                                s1_valid;
  fpu_ic_pkg::fpu_req_t                s1_req;
  fp_class_t                           s1_cls_a;
  fp_class_t                           s1_cls_b;
  // Stage 2 state
  logic                                s2_valid;
  fpu_ic_pkg::apu_rsp_t                s2_rsp;
  // Handshake helpers
  logic                                s2_ready;
  logic                                s1_advance;
  logic                                in_fire;
  // Stage 2 next values
  logic [fpu_ic_pkg::DATA_WIDTH-1:0]   res_d;
  fpu_ic_pkg::fp_status_t              flags_d;
  logic [fpu_ic_pkg::DATA_WIDTH-2:0]   mag_a;
  logic [fpu_ic_pkg::DATA_WIDTH-2:0]   mag_b;
  logic                                a_nan;
  logic                                b_nan;
  logic                                any_snan;
  logic                                both_zero;
  logic                                a_lt_b;
  logic                                ord_lt;
  logic                                ord_eq;
  logic [fpu_ic_pkg::CLASS_WIDTH-1:0]  class_mask;

  // -----------------------------------------------
  // Pipeline control
  // -----------------------------------------------
  // Stage 2 can take new data when empty or draining
  assign s2_ready   = !s2_valid || out_ready_i;
  assign s1_advance = s1_valid && s2_ready;
  assign in_ready_o = !s1_valid || s2_ready;
  assign in_fire    = in_valid_i && in_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin : valid_ff
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (in_ready_o) begin
        s1_valid <= in_valid_i;
      end
      if (s2_ready) begin
        s2_valid <= s1_valid;
      end
    end
  end

  always_ff @(posedge clk) begin : data_ff
    if (in_fire) begin
      s1_req   <= in_req_i;
      s1_cls_a <= classify(in_req_i.op_a);
      s1_cls_b <= classify(in_req_i.op_b);
    end
    if (s1_advance) begin
      s2_rsp.result <= res_d;
      s2_rsp.flags  <= flags_d;
      s2_rsp.id     <= s1_req.tag;
    end
  end

  // -----------------------------------------------
  // Stage 2 datapath
  // -----------------------------------------------
  assign mag_a     = s1_req.op_a[fpu_ic_pkg::DATA_WIDTH-2:0];
  assign mag_b     = s1_req.op_b[fpu_ic_pkg::DATA_WIDTH-2:0];
  assign a_nan     = s1_cls_a.qnan || s1_cls_a.snan;
  assign b_nan     = s1_cls_b.qnan || s1_cls_b.snan;
  assign any_snan  = s1_cls_a.snan || s1_cls_b.snan;
  assign both_zero = s1_cls_a.zero && s1_cls_b.zero;

  // Total order on sign-magnitude, -0 below +0
  assign a_lt_b = (s1_cls_a.sign != s1_cls_b.sign) ? s1_cls_a.sign :
                  s1_cls_a.sign ? (mag_b < mag_a) : (mag_a < mag_b);
  // IEEE compare treats the two zeros as equal
  assign ord_lt = a_lt_b && !both_zero;
  assign ord_eq = (s1_req.op_a == s1_req.op_b) || both_zero;

  // fclass bits, negative classes first
  assign class_mask[0] = s1_cls_a.sign && s1_cls_a.inf;
  assign class_mask[1] = s1_cls_a.sign && s1_cls_a.normal;
  assign class_mask[2] = s1_cls_a.sign && s1_cls_a.subnormal;
  assign class_mask[3] = s1_cls_a.sign && s1_cls_a.zero;
  assign class_mask[4] = !s1_cls_a.sign && s1_cls_a.zero;
  assign class_mask[5] = !s1_cls_a.sign && s1_cls_a.subnormal;
  assign class_mask[6] = !s1_cls_a.sign && s1_cls_a.normal;
  assign class_mask[7] = !s1_cls_a.sign && s1_cls_a.inf;
  assign class_mask[8] = s1_cls_a.snan;
  assign class_mask[9] = s1_cls_a.qnan;

  always_comb begin : result_comb
    res_d   = '0;
    flags_d = '0;
    case (s1_req.op)
      fpu_ic_pkg::OP_SGNJ: begin
        // Magnitude of A, sign picked per sub-op
        case (s1_req.rnd)
          fpu_ic_pkg::SGNJ_JN: res_d = {!s1_cls_b.sign, mag_a};
          fpu_ic_pkg::SGNJ_JX: res_d = {s1_cls_a.sign ^ s1_cls_b.sign, mag_a};
          default:             res_d = {s1_cls_b.sign, mag_a};
        endcase
      end
      fpu_ic_pkg::OP_MINMAX: begin
        flags_d.nv = any_snan;
        if (a_nan && b_nan) begin
          res_d = fpu_ic_pkg::CANONICAL_NAN;
        end else if (a_nan) begin
          res_d = s1_req.op_b;
        end else if (b_nan) begin
          res_d = s1_req.op_a;
        end else if (s1_req.rnd == fpu_ic_pkg::MM_MAX) begin
          res_d = a_lt_b ? s1_req.op_b : s1_req.op_a;
        end else begin
          res_d = a_lt_b ? s1_req.op_a : s1_req.op_b;
        end
      end
      fpu_ic_pkg::OP_CMP: begin
        if (a_nan || b_nan) begin
          // Quiet EQ only signals on sNaN
          flags_d.nv = (s1_req.rnd == fpu_ic_pkg::CMP_EQ) ? any_snan : 1'b1;
        end else begin
          case (s1_req.rnd)
            fpu_ic_pkg::CMP_LT: res_d[0] = ord_lt;
            fpu_ic_pkg::CMP_EQ: res_d[0] = ord_eq;
            default:            res_d[0] = ord_lt || ord_eq;
          endcase
        end
      end
      fpu_ic_pkg::OP_CLASS: begin
        res_d[fpu_ic_pkg::CLASS_WIDTH-1:0] = class_mask;
      end
      default: begin
        res_d = '0;
      end
    endcase
  end

  assign out_valid_o = s2_valid;
  assign out_rsp_o   = s2_rsp;

endmodule

// ==== hw/fpu_ic_pkg.sv ====
// -----------------------------------------------
// Shared FPU interconnect definitions
// -----------------------------------------------
package fpu_ic_pkg;

  // -----------------------------------------------
  // Sizes
  // -----------------------------------------------
  localparam int NB_CORES        = 2;
  localparam int DATA_WIDTH      = 32;
  // Tag carries the core index
  localparam int ID_WIDTH        = 1;
  localparam int FLAGS_OUT_WIDTH = 5;
  localparam int OP_WIDTH        = 2;
  localparam int RND_WIDTH       = 3;

  // FP32 field widths
  localparam int EXP_BITS        = 8;
  localparam int MAN_BITS        = 23;
  // RISC-V fclass mask width
  localparam int CLASS_WIDTH     = 10;

  // Quiet NaN returned by min/max on two NaNs
  localparam logic [DATA_WIDTH-1:0] CANONICAL_NAN = 32'h7FC0_0000;

  // -----------------------------------------------
  // Operation and sub-operation encodings
  // -----------------------------------------------
  typedef enum logic [OP_WIDTH-1:0] {
    OP_SGNJ   = 2'd0,
    OP_MINMAX = 2'd1,
    OP_CMP    = 2'd2,
    OP_CLASS  = 2'd3
  } fpu_op_e;

  // Rounding-mode field, reused as sub-operation
  typedef logic [RND_WIDTH-1:0] fp_rnd_t;

  // Sign injection
  localparam fp_rnd_t SGNJ_J  = 3'd0;
  localparam fp_rnd_t SGNJ_JN = 3'd1;
  localparam fp_rnd_t SGNJ_JX = 3'd2;
  // Min / max
  localparam fp_rnd_t MM_MIN  = 3'd0;
  localparam fp_rnd_t MM_MAX  = 3'd1;
  // Compare
  localparam fp_rnd_t CMP_LE  = 3'd0;
  localparam fp_rnd_t CMP_LT  = 3'd1;
  localparam fp_rnd_t CMP_EQ  = 3'd2;

  // Status flags, NV in the top bit
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_status_t;

  // -----------------------------------------------
  // Channel payloads
  // -----------------------------------------------
  // Raw request as issued by a core
  typedef struct packed {
    logic [DATA_WIDTH-1:0] op_a;
    logic [DATA_WIDTH-1:0] op_b;
    logic [OP_WIDTH-1:0]   op;
    logic [RND_WIDTH-1:0]  flags;
    logic [ID_WIDTH-1:0]   id;
  } apu_req_t;

  // Decoded request seen by the execution unit
  typedef struct packed {
    logic [DATA_WIDTH-1:0] op_a;
    logic [DATA_WIDTH-1:0] op_b;
    fpu_op_e               op;
    fp_rnd_t               rnd;
    logic [ID_WIDTH-1:0]   tag;
  } fpu_req_t;

  // Response back to a core
  typedef struct packed {
    logic [DATA_WIDTH-1:0] result;
    fp_status_t            flags;
    logic [ID_WIDTH-1:0]   id;
  } apu_rsp_t;

endpackage
